// File: src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [8:0]  hw_int_t;
    typedef logic [12:0] int_vec_t;

    // estat bit 11 already carries the timer pending bit
    typedef struct packed {
        csr_data_t crmd;
        csr_data_t prmd;
        csr_data_t ectl;
        csr_data_t estat;
        csr_data_t era;
        csr_data_t eentry;
    } trap_state_t;

    typedef struct packed {
        csr_data_t tid;
        csr_data_t tcfg;
        csr_data_t tval;
    } timer_state_t;

    // csr numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECTL   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_EENTRY = 14'hc;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_TID    = 14'h40;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;

    localparam int CRMD_PLV_LSB = 0;
    localparam int CRMD_PLV_MSB = 1;
    localparam int CRMD_IE      = 2;

    localparam int PRMD_PPLV_LSB = 0;
    localparam int PRMD_PPLV_MSB = 1;
    localparam int PRMD_PIE      = 2;

    // estat status field layout
    localparam int ESTAT_SW_MSB       = 1;
    localparam int ESTAT_HWI_LSB      = 2;
    localparam int ESTAT_HWI_MSB      = 10;
    localparam int ESTAT_TI           = 11;
    localparam int ESTAT_IS_MSB       = 12;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ECODE_MSB    = 21;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int ESTAT_ESUBCODE_MSB = 30;

    // lie bits 12:11 and 9:0
    localparam int_vec_t ECTL_LIE_MASK = 13'h1bff;

    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;
    localparam int TCFG_INITVAL_MSB = 31;

    localparam int TICLR_CLR = 0;

    localparam int EENTRY_ALIGN = 6;
    localparam int N_SAVE_MAX   = 16;

endpackage

`default_nettype wire

// File: src/csr_update_if.sv
`default_nettype none

interface csr_update_if;

    // selected write
    logic                 we;
    csr_pkg::csr_addr_t   waddr;
    csr_pkg::csr_data_t   wdata;

    // trap events
    logic                 excp_flush;
    logic                 ertn_flush;
    csr_pkg::ecode_t      ecode;
    csr_pkg::esubcode_t   esubcode;
    csr_pkg::csr_data_t   era;

    // registered interrupt lines
    csr_pkg::hw_int_t     hw_int;

    modport src (
        output we, waddr, wdata,
        output excp_flush, ertn_flush, ecode, esubcode, era,
        output hw_int
    );

    modport dst (
        input we, waddr, wdata,
        input excp_flush, ertn_flush, ecode, esubcode, era,
        input hw_int
    );

endinterface

`default_nettype wire

// File: src/csr_write_select.sv
`default_nettype none

module csr_write_select (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr1_we_i,
    input  csr_pkg::csr_addr_t wr1_addr_i,
    input  csr_pkg::csr_data_t wr1_data_i,
    input  logic               wr2_we_i,
    input  csr_pkg::csr_addr_t wr2_addr_i,
    input  csr_pkg::csr_data_t wr2_data_i,
    input  logic               excp_flush_i,
    input  logic               ertn_flush_i,
    input  csr_pkg::ecode_t    ecode_i,
    input  csr_pkg::esubcode_t esubcode_i,
    input  csr_pkg::csr_data_t era_i,
    input  csr_pkg::hw_int_t   hw_int_i,
    csr_update_if.src          upd
);

    csr_pkg::hw_int_t hw_int_q;

    // port 1 has priority on a collision
    assign upd.we    = wr1_we_i | wr2_we_i;
    assign upd.waddr = wr1_we_i ? wr1_addr_i : wr2_addr_i;
    assign upd.wdata = wr1_we_i ? wr1_data_i : wr2_data_i;

    assign upd.excp_flush = excp_flush_i;
    assign upd.ertn_flush = ertn_flush_i;
    assign upd.ecode      = ecode_i;
    assign upd.esubcode   = esubcode_i;
    assign upd.era        = era_i;

    // one sampling stage for the interrupt pins
    always_ff @(posedge clk) begin
        if (rst) begin
            hw_int_q <= '0;
        end else begin
            hw_int_q <= hw_int_i;
        end
    end

    assign upd.hw_int = hw_int_q;

    a_flush_exclusive : assert property (
        @(posedge clk) disable iff (rst) !(excp_flush_i && ertn_flush_i)
    );

endmodule

`default_nettype wire

// File: src/csr_trap_regs.sv
`default_nettype none

module csr_trap_regs #(
    parameter int N_SAVE = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    csr_update_if.dst            upd,
    input  logic                 ti_i,
    output csr_pkg::trap_state_t state_o,
    output csr_pkg::csr_data_t   save_o [N_SAVE],
    output csr_pkg::plv_t        plv_o,
    output logic                 has_int_o
);

    csr_pkg::plv_t      crmd_plv;
    logic               crmd_ie;
    csr_pkg::plv_t      prmd_pplv;
    logic               prmd_pie;
    csr_pkg::int_vec_t  ectl_lie;
    logic [csr_pkg::ESTAT_SW_MSB:0] estat_sw;
    csr_pkg::hw_int_t   estat_hwi;
    csr_pkg::ecode_t    estat_ecode;
    csr_pkg::esubcode_t estat_esubcode;
    csr_pkg::csr_data_t era_q;
    logic [31:csr_pkg::EENTRY_ALIGN] eentry_hi;
    csr_pkg::int_vec_t  estat_is;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ectl;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    assign wr_crmd   = upd.we && (upd.waddr == csr_pkg::CSR_CRMD);
    assign wr_prmd   = upd.we && (upd.waddr == csr_pkg::CSR_PRMD);
    assign wr_ectl   = upd.we && (upd.waddr == csr_pkg::CSR_ECTL);
    assign wr_estat  = upd.we && (upd.waddr == csr_pkg::CSR_ESTAT);
    assign wr_era    = upd.we && (upd.waddr == csr_pkg::CSR_ERA);
    assign wr_eentry = upd.we && (upd.waddr == csr_pkg::CSR_EENTRY);

    // for crmd entry beats return beats write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (upd.excp_flush) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (upd.ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= upd.wdata[csr_pkg::CRMD_PLV_MSB:csr_pkg::CRMD_PLV_LSB];
            crmd_ie  <= upd.wdata[csr_pkg::CRMD_IE];
        end
    end

    // prmd saves the previous mode on entry
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (upd.excp_flush) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= upd.wdata[csr_pkg::PRMD_PPLV_MSB:csr_pkg::PRMD_PPLV_LSB];
            prmd_pie  <= upd.wdata[csr_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_lie <= '0;
        end else if (wr_ectl) begin
            ectl_lie <= upd.wdata[csr_pkg::ESTAT_IS_MSB:0] & csr_pkg::ECTL_LIE_MASK;
        end
    end

    // hw interrupt bits track the sampled lines every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            estat_sw       <= '0;
            estat_hwi      <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else begin
            estat_hwi <= upd.hw_int;
            if (upd.excp_flush) begin
                estat_ecode    <= upd.ecode;
                estat_esubcode <= upd.esubcode;
            end
            if (wr_estat) begin
                estat_sw <= upd.wdata[csr_pkg::ESTAT_SW_MSB:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.excp_flush) begin
            era_q <= upd.era;
        end else if (wr_era) begin
            era_q <= upd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_hi <= '0;
        end else if (wr_eentry) begin
            eentry_hi <= upd.wdata[31:csr_pkg::EENTRY_ALIGN];
        end
    end

    for (genvar i = 0; i < N_SAVE; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (upd.we && upd.waddr == csr_pkg::csr_addr_t'(csr_pkg::CSR_SAVE0 + i)) begin
                save_o[i] <= upd.wdata;
            end
        end
    end

    // ipi bit 12 is not implemented
    assign estat_is = {1'b0, ti_i, estat_hwi, estat_sw};

    always_comb begin
        state_o = '0;
        state_o.crmd[csr_pkg::CRMD_PLV_MSB:csr_pkg::CRMD_PLV_LSB] = crmd_plv;
        state_o.crmd[csr_pkg::CRMD_IE] = crmd_ie;
        state_o.prmd[csr_pkg::PRMD_PPLV_MSB:csr_pkg::PRMD_PPLV_LSB] = prmd_pplv;
        state_o.prmd[csr_pkg::PRMD_PIE] = prmd_pie;
        state_o.ectl[csr_pkg::ESTAT_IS_MSB:0] = ectl_lie;
        state_o.estat[csr_pkg::ESTAT_IS_MSB:0] = estat_is;
        state_o.estat[csr_pkg::ESTAT_ECODE_MSB:csr_pkg::ESTAT_ECODE_LSB] = estat_ecode;
        state_o.estat[csr_pkg::ESTAT_ESUBCODE_MSB:csr_pkg::ESTAT_ESUBCODE_LSB] =
            estat_esubcode;
        state_o.era = era_q;
        state_o.eentry[31:csr_pkg::EENTRY_ALIGN] = eentry_hi;
    end

    assign has_int_o = crmd_ie && |(ectl_lie & estat_is);

    // forward the level the next instruction will run at
    always_comb begin
        if (upd.excp_flush) begin
            plv_o = '0;
        end else if (upd.ertn_flush) begin
            plv_o = prmd_pplv;
        end else if (wr_crmd) begin
            plv_o = upd.wdata[csr_pkg::CRMD_PLV_MSB:csr_pkg::CRMD_PLV_LSB];
        end else begin
            plv_o = crmd_plv;
        end
    end

    a_entry_masks_int : assert property (
        @(posedge clk) disable iff (rst) upd.excp_flush |=> !crmd_ie
    );

endmodule

`default_nettype wire

// File: src/csr_timer.sv
`default_nettype none

module csr_timer (
    input  logic                  clk,
    input  logic                  rst,
    csr_update_if.dst             upd,
    output csr_pkg::timer_state_t state_o,
    output logic                  ti_o
);

    csr_pkg::csr_data_t tid_q;
    csr_pkg::csr_data_t tcfg_q;
    csr_pkg::csr_data_t tval_q;
    csr_pkg::csr_data_t reload_val;
    csr_pkg::csr_data_t load_val;
    logic               timer_en;
    logic               ti_q;
    logic               tid_we;
    logic               tcfg_we;
    logic               ticlr_clr;
    logic               expire;

    assign tid_we    = upd.we && (upd.waddr == csr_pkg::CSR_TID);
    assign tcfg_we   = upd.we && (upd.waddr == csr_pkg::CSR_TCFG);
    assign ticlr_clr = upd.we && (upd.waddr == csr_pkg::CSR_TICLR)
                       && upd.wdata[csr_pkg::TICLR_CLR];

    // initval with the low two bits forced to zero
    assign load_val = {upd.wdata[csr_pkg::TCFG_INITVAL_MSB:csr_pkg::TCFG_INITVAL_LSB],
                       {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
    assign reload_val = {tcfg_q[csr_pkg::TCFG_INITVAL_MSB:csr_pkg::TCFG_INITVAL_LSB],
                         {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};

    // a tcfg write in the same cycle hides the expiry
    assign expire = timer_en && (tval_q == '0) && !tcfg_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q <= '0;
        end else if (tid_we) begin
            tid_q <= upd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q   <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_we) begin
            tcfg_q   <= upd.wdata;
            timer_en <= upd.wdata[csr_pkg::TCFG_EN];
        end else if (expire) begin
            // one-shot stops, periodic keeps going
            timer_en <= tcfg_q[csr_pkg::TCFG_PERIODIC];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tval_q <= '0;
        end else if (tcfg_we) begin
            tval_q <= load_val;
        end else if (expire) begin
            tval_q <= tcfg_q[csr_pkg::TCFG_PERIODIC] ? reload_val : '1;
        end else if (timer_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // clear wins over a new expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_clr) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    assign state_o = '{tid: tid_q, tcfg: tcfg_q, tval: tval_q};
    assign ti_o    = ti_q;

    a_tval_frozen : assert property (
        @(posedge clk) disable iff (rst) (!timer_en && !tcfg_we) |=> $stable(tval_q)
    );

endmodule

`default_nettype wire

// File: src/csr_read_mux.sv
`default_nettype none

module csr_read_mux #(
    parameter int N_SAVE = 4
) (
    input  csr_pkg::csr_addr_t    raddr_i,
    input  csr_pkg::trap_state_t  trap_i,
    input  csr_pkg::csr_data_t    save_i [N_SAVE],
    input  csr_pkg::timer_state_t timer_i,
    output csr_pkg::csr_data_t    rdata_o
);

    always_comb begin
        rdata_o = '0;
        case (raddr_i)
            csr_pkg::CSR_CRMD: begin
                rdata_o = trap_i.crmd;
            end
            csr_pkg::CSR_PRMD: begin
                rdata_o = trap_i.prmd;
            end
            csr_pkg::CSR_ECTL: begin
                rdata_o = trap_i.ectl;
            end
            csr_pkg::CSR_ESTAT: begin
                rdata_o = trap_i.estat;
            end
            csr_pkg::CSR_ERA: begin
                rdata_o = trap_i.era;
            end
            csr_pkg::CSR_EENTRY: begin
                rdata_o = trap_i.eentry;
            end
            csr_pkg::CSR_TID: begin
                rdata_o = timer_i.tid;
            end
            csr_pkg::CSR_TCFG: begin
                rdata_o = timer_i.tcfg;
            end
            csr_pkg::CSR_TVAL: begin
                rdata_o = timer_i.tval;
            end
            // ticlr and unknown numbers read as zero
            default: begin
                rdata_o = '0;
            end
        endcase

        // save window sits outside the case items
        for (int i = 0; i < N_SAVE; i++) begin
            if (raddr_i == csr_pkg::CSR_SAVE0 + csr_pkg::csr_addr_t'(i)) begin
                rdata_o = save_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/csr_file_top.sv
`default_nettype none

module csr_file_top #(
    parameter int N_SAVE = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               wr1_we_i,
    input  csr_pkg::csr_addr_t wr1_addr_i,
    input  csr_pkg::csr_data_t wr1_data_i,
    input  logic               wr2_we_i,
    input  csr_pkg::csr_addr_t wr2_addr_i,
    input  csr_pkg::csr_data_t wr2_data_i,

    input  logic               excp_flush_i,
    input  logic               ertn_flush_i,
    input  csr_pkg::ecode_t    ecode_i,
    input  csr_pkg::esubcode_t esubcode_i,
    input  csr_pkg::csr_data_t era_i,
    input  csr_pkg::hw_int_t   hw_int_i,

    input  csr_pkg::csr_addr_t raddr_i,
    output csr_pkg::csr_data_t rdata_o,

    output csr_pkg::plv_t      plv_o,
    output logic               has_int_o,
    output csr_pkg::csr_data_t era_o,
    output csr_pkg::csr_data_t eentry_o,
    output csr_pkg::csr_data_t tid_o
);

    csr_pkg::trap_state_t  trap_state;
    csr_pkg::timer_state_t timer_state;
    csr_pkg::csr_data_t    save_regs [N_SAVE];
    logic                  timer_int;

    if (N_SAVE < 1 || N_SAVE > csr_pkg::N_SAVE_MAX) begin : g_bad_n_save
        $error("csr_file_top: N_SAVE must lie between 1 and N_SAVE_MAX");
    end

    csr_update_if upd ();

    csr_write_select u_write_select (
        .clk          (clk),
        .rst          (rst),
        .wr1_we_i     (wr1_we_i),
        .wr1_addr_i   (wr1_addr_i),
        .wr1_data_i   (wr1_data_i),
        .wr2_we_i     (wr2_we_i),
        .wr2_addr_i   (wr2_addr_i),
        .wr2_data_i   (wr2_data_i),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .hw_int_i     (hw_int_i),
        .upd          (upd.src)
    );

    csr_trap_regs #(
        .N_SAVE (N_SAVE)
    ) u_trap_regs (
        .clk       (clk),
        .rst       (rst),
        .upd       (upd.dst),
        .ti_i      (timer_int),
        .state_o   (trap_state),
        .save_o    (save_regs),
        .plv_o     (plv_o),
        .has_int_o (has_int_o)
    );

    csr_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .upd     (upd.dst),
        .state_o (timer_state),
        .ti_o    (timer_int)
    );

    csr_read_mux #(
        .N_SAVE (N_SAVE)
    ) u_read_mux (
        .raddr_i (raddr_i),
        .trap_i  (trap_state),
        .save_i  (save_regs),
        .timer_i (timer_state),
        .rdata_o (rdata_o)
    );

    // exception vector and return address for the fetch stage
    assign era_o    = trap_state.era;
    assign eentry_o = trap_state.eentry;
    assign tid_o    = timer_state.tid;

endmodule

`default_nettype wire

// File: testbench/csr_ref_model.sv
`default_nettype none

module csr_ref_model #(
    parameter int N_SAVE = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr1_we_i,
    input  csr_pkg::csr_addr_t wr1_addr_i,
    input  csr_pkg::csr_data_t wr1_data_i,
    input  logic               wr2_we_i,
    input  csr_pkg::csr_addr_t wr2_addr_i,
    input  csr_pkg::csr_data_t wr2_data_i,
    input  logic               excp_flush_i,
    input  logic               ertn_flush_i,
    input  csr_pkg::ecode_t    ecode_i,
    input  csr_pkg::esubcode_t esubcode_i,
    input  csr_pkg::csr_data_t era_i,
    input  csr_pkg::hw_int_t   hw_int_i,
    input  csr_pkg::csr_addr_t raddr_i,
    output csr_pkg::csr_data_t exp_rdata_o,
    output csr_pkg::plv_t      exp_plv_o,
    output logic               exp_has_int_o,
    output csr_pkg::csr_data_t exp_era_o,
    output csr_pkg::csr_data_t exp_eentry_o,
    output csr_pkg::csr_data_t exp_tid_o
);

    csr_pkg::csr_data_t m_crmd;
    csr_pkg::csr_data_t m_prmd;
    csr_pkg::csr_data_t m_ectl;
    logic [1:0]         m_sw;
    csr_pkg::ecode_t    m_ecode;
    csr_pkg::esubcode_t m_esub;
    csr_pkg::csr_data_t m_era;
    csr_pkg::csr_data_t m_eentry;
    csr_pkg::csr_data_t m_save [N_SAVE];
    csr_pkg::csr_data_t m_tid;
    csr_pkg::csr_data_t m_tcfg;
    csr_pkg::csr_data_t m_tval;
    logic               m_ten;
    logic               m_ti;
    csr_pkg::hw_int_t   hw_s1;
    csr_pkg::hw_int_t   hw_s2;

    logic               w_en;
    csr_pkg::csr_addr_t w_addr;
    csr_pkg::csr_data_t w_data;
    logic               cfg_wr;
    logic               clr;
    logic               fire;
    csr_pkg::csr_data_t estat_rd;

    // port 1 wins a collision
    assign w_en   = wr1_we_i || wr2_we_i;
    assign w_addr = wr1_we_i ? wr1_addr_i : wr2_addr_i;
    assign w_data = wr1_we_i ? wr1_data_i : wr2_data_i;

    assign cfg_wr = w_en && (w_addr == csr_pkg::CSR_TCFG);
    assign clr    = w_en && (w_addr == csr_pkg::CSR_TICLR) && w_data[0];
    assign fire   = m_ten && (m_tval == 32'h0) && !cfg_wr;

    always @(posedge clk) begin
        if (rst) begin
            m_crmd   <= '0;
            m_prmd   <= '0;
            m_ectl   <= '0;
            m_sw     <= '0;
            m_ecode  <= '0;
            m_esub   <= '0;
            m_eentry <= '0;
            m_tid    <= '0;
            m_tcfg   <= '0;
            m_tval   <= '0;
            m_ten    <= 1'b0;
            m_ti     <= 1'b0;
            hw_s1    <= '0;
            hw_s2    <= '0;
        end else begin
            hw_s1 <= hw_int_i;
            hw_s2 <= hw_s1;
            if (w_en) begin
                case (w_addr)
                    csr_pkg::CSR_CRMD: m_crmd <= w_data & 32'h7;
                    csr_pkg::CSR_PRMD: m_prmd <= w_data & 32'h7;
                    csr_pkg::CSR_ECTL: m_ectl <= w_data & 32'h1bff;
                    csr_pkg::CSR_ESTAT: m_sw <= w_data[1:0];
                    csr_pkg::CSR_ERA: m_era <= w_data;
                    csr_pkg::CSR_EENTRY: m_eentry <= {w_data[31:6], 6'b0};
                    csr_pkg::CSR_TID: m_tid <= w_data;
                    default: begin
                        if (w_addr >= csr_pkg::CSR_SAVE0 &&
                            w_addr < csr_pkg::CSR_SAVE0 + N_SAVE) begin
                            m_save[w_addr - csr_pkg::CSR_SAVE0] <= w_data;
                        end
                    end
                endcase
            end
            // later assignments override the write above
            if (ertn_flush_i) begin
                m_crmd <= {29'b0, m_prmd[2:0]};
            end
            if (excp_flush_i) begin
                m_prmd  <= {29'b0, m_crmd[2:0]};
                m_crmd  <= '0;
                m_ecode <= ecode_i;
                m_esub  <= esubcode_i;
                m_era   <= era_i;
            end

            if (cfg_wr) begin
                m_tcfg <= w_data;
                m_ten  <= w_data[0];
                m_tval <= w_data & ~32'h3;
            end else if (fire) begin
                if (m_tcfg[1]) begin
                    m_tval <= m_tcfg & ~32'h3;
                end else begin
                    m_tval <= 32'hffff_ffff;
                    m_ten  <= 1'b0;
                end
            end else if (m_ten) begin
                m_tval <= m_tval - 32'h1;
            end
            if (clr) begin
                m_ti <= 1'b0;
            end else if (fire) begin
                m_ti <= 1'b1;
            end
        end
    end

    assign estat_rd = {1'b0, m_esub, m_ecode, 3'b000, 1'b0, m_ti, hw_s2, m_sw};

    always_comb begin
        case (raddr_i)
            csr_pkg::CSR_CRMD: exp_rdata_o = m_crmd;
            csr_pkg::CSR_PRMD: exp_rdata_o = m_prmd;
            csr_pkg::CSR_ECTL: exp_rdata_o = m_ectl;
            csr_pkg::CSR_ESTAT: exp_rdata_o = estat_rd;
            csr_pkg::CSR_ERA: exp_rdata_o = m_era;
            csr_pkg::CSR_EENTRY: exp_rdata_o = m_eentry;
            csr_pkg::CSR_TID: exp_rdata_o = m_tid;
            csr_pkg::CSR_TCFG: exp_rdata_o = m_tcfg;
            csr_pkg::CSR_TVAL: exp_rdata_o = m_tval;
            default: begin
                exp_rdata_o = '0;
                if (raddr_i >= csr_pkg::CSR_SAVE0 && raddr_i < csr_pkg::CSR_SAVE0 + N_SAVE) begin
                    exp_rdata_o = m_save[raddr_i - csr_pkg::CSR_SAVE0];
                end
            end
        endcase
    end

    always_comb begin
        if (excp_flush_i) begin
            exp_plv_o = 2'd0;
        end else if (ertn_flush_i) begin
            exp_plv_o = m_prmd[1:0];
        end else if (w_en && w_addr == csr_pkg::CSR_CRMD) begin
            exp_plv_o = w_data[1:0];
        end else begin
            exp_plv_o = m_crmd[1:0];
        end
    end

    assign exp_has_int_o = m_crmd[2] && |(m_ectl[12:0] & estat_rd[12:0]);
    assign exp_era_o     = m_era;
    assign exp_eentry_o  = m_eentry;
    assign exp_tid_o     = m_tid;

endmodule

`default_nettype wire

// File: testbench/csr_tb.sv
`default_nettype none

module csr_tb;

    localparam int N_SAVE     = 4;
    localparam int N_CYCLES   = 3000;
    localparam int CLK_PERIOD = 40;
    localparam int POOL_SIZE  = N_SAVE + 11;

    logic               clk;
    logic               rst;
    logic               wr1_we_i;
    csr_pkg::csr_addr_t wr1_addr_i;
    csr_pkg::csr_data_t wr1_data_i;
    logic               wr2_we_i;
    csr_pkg::csr_addr_t wr2_addr_i;
    csr_pkg::csr_data_t wr2_data_i;
    logic               excp_flush_i;
    logic               ertn_flush_i;
    csr_pkg::ecode_t    ecode_i;
    csr_pkg::esubcode_t esubcode_i;
    csr_pkg::csr_data_t era_i;
    csr_pkg::hw_int_t   hw_int_i;
    csr_pkg::csr_addr_t raddr_i;
    csr_pkg::csr_data_t rdata_o;
    csr_pkg::plv_t      plv_o;
    logic               has_int_o;
    csr_pkg::csr_data_t era_o;
    csr_pkg::csr_data_t eentry_o;
    csr_pkg::csr_data_t tid_o;

    csr_pkg::csr_data_t exp_rdata;
    csr_pkg::plv_t      exp_plv;
    logic               exp_has_int;
    csr_pkg::csr_data_t exp_era;
    csr_pkg::csr_data_t exp_eentry;
    csr_pkg::csr_data_t exp_tid;

    integer             seed;
    csr_pkg::csr_addr_t addr_pool [POOL_SIZE];

    csr_file_top #(
        .N_SAVE (N_SAVE)
    ) dut0 (
        .clk (clk), .rst (rst),
        .wr1_we_i (wr1_we_i), .wr1_addr_i (wr1_addr_i), .wr1_data_i (wr1_data_i),
        .wr2_we_i (wr2_we_i), .wr2_addr_i (wr2_addr_i), .wr2_data_i (wr2_data_i),
        .excp_flush_i (excp_flush_i), .ertn_flush_i (ertn_flush_i),
        .ecode_i (ecode_i), .esubcode_i (esubcode_i), .era_i (era_i),
        .hw_int_i (hw_int_i), .raddr_i (raddr_i), .rdata_o (rdata_o),
        .plv_o (plv_o), .has_int_o (has_int_o),
        .era_o (era_o), .eentry_o (eentry_o), .tid_o (tid_o)
    );

    csr_ref_model #(
        .N_SAVE (N_SAVE)
    ) model (
        .clk (clk), .rst (rst),
        .wr1_we_i (wr1_we_i), .wr1_addr_i (wr1_addr_i), .wr1_data_i (wr1_data_i),
        .wr2_we_i (wr2_we_i), .wr2_addr_i (wr2_addr_i), .wr2_data_i (wr2_data_i),
        .excp_flush_i (excp_flush_i), .ertn_flush_i (ertn_flush_i),
        .ecode_i (ecode_i), .esubcode_i (esubcode_i), .era_i (era_i),
        .hw_int_i (hw_int_i), .raddr_i (raddr_i), .exp_rdata_o (exp_rdata),
        .exp_plv_o (exp_plv), .exp_has_int_o (exp_has_int),
        .exp_era_o (exp_era), .exp_eentry_o (exp_eentry), .exp_tid_o (exp_tid)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_mismatch();
        $display("*** FAILED ***");
        $fatal(1, "first mismatch reached");
    endtask

    task automatic check_data(input string name, input csr_pkg::csr_data_t exp,
                              input csr_pkg::csr_data_t act);
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h actual 0x%h (raddr 0x%h)", name, exp, act, raddr_i);
            stop_on_mismatch();
        end
    endtask

    task automatic check_plv(input string name, input csr_pkg::plv_t exp,
                             input csr_pkg::plv_t act);
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    task automatic check_int(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, exp, act);
            stop_on_mismatch();
        end
    endtask

    function automatic int unsigned draw_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // mostly kept registers and sometimes a fully random number
    function automatic csr_pkg::csr_addr_t pick_addr();
        int unsigned k;
        k = draw_below(POOL_SIZE + 1);
        if (k < POOL_SIZE) begin
            return addr_pool[k];
        end
        return csr_pkg::csr_addr_t'($random(seed));
    endfunction

    function automatic csr_pkg::csr_data_t make_wdata(input csr_pkg::csr_addr_t addr);
        csr_pkg::csr_data_t data;
        data = $random(seed);
        if (addr == csr_pkg::CSR_TCFG) begin
            // short countdowns so expiry shows up often
            data = (draw_below(8) << 2) | draw_below(4);
        end else if (addr == csr_pkg::CSR_TICLR) begin
            data[0] = (draw_below(4) != 0);
        end
        return data;
    endfunction

    // at most one of write, excp_flush and ertn_flush per cycle
    task automatic drive_cycle();
        int unsigned ev;
        int unsigned mode;
        ev = draw_below(20);
        wr1_we_i     = 1'b0;
        wr2_we_i     = 1'b0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        wr1_addr_i   = pick_addr();
        wr1_data_i   = make_wdata(wr1_addr_i);
        wr2_addr_i   = pick_addr();
        wr2_data_i   = make_wdata(wr2_addr_i);
        ecode_i      = csr_pkg::ecode_t'($random(seed));
        esubcode_i   = csr_pkg::esubcode_t'($random(seed));
        era_i        = $random(seed);
        if (draw_below(4) == 0) begin
            hw_int_i = csr_pkg::hw_int_t'($random(seed));
        end
        if (ev == 0) begin
            excp_flush_i = 1'b1;
        end else if (ev == 1) begin
            ertn_flush_i = 1'b1;
        end else if (ev < 10) begin
            mode     = draw_below(4);
            wr1_we_i = (mode != 1);
            wr2_we_i = (mode != 0);
        end
        raddr_i = pick_addr();
    endtask

    task automatic check_outputs();
        check_data("rdata_o", exp_rdata, rdata_o);
        check_data("era_o", exp_era, era_o);
        check_data("eentry_o", exp_eentry, eentry_o);
        check_data("tid_o", exp_tid, tid_o);
        check_plv("plv_o", exp_plv, plv_o);
        check_int("has_int_o", exp_has_int, has_int_o);
    endtask

    initial begin
        seed = 84;
        addr_pool[0]  = csr_pkg::CSR_CRMD;
        addr_pool[1]  = csr_pkg::CSR_PRMD;
        addr_pool[2]  = csr_pkg::CSR_ECTL;
        addr_pool[3]  = csr_pkg::CSR_ESTAT;
        addr_pool[4]  = csr_pkg::CSR_ERA;
        addr_pool[5]  = csr_pkg::CSR_EENTRY;
        addr_pool[6]  = csr_pkg::CSR_TID;
        addr_pool[7]  = csr_pkg::CSR_TCFG;
        addr_pool[8]  = csr_pkg::CSR_TVAL;
        addr_pool[9]  = csr_pkg::CSR_TICLR;
        // one past the save window is unmapped
        addr_pool[10] = csr_pkg::CSR_SAVE0 + N_SAVE;
        for (int i = 0; i < N_SAVE; i++) begin
            addr_pool[11 + i] = csr_pkg::CSR_SAVE0 + i;
        end

        rst          = 1'b1;
        wr1_we_i     = 1'b0;
        wr1_addr_i   = '0;
        wr1_data_i   = '0;
        wr2_we_i     = 1'b0;
        wr2_addr_i   = '0;
        wr2_data_i   = '0;
        excp_flush_i = 1'b0;
        ertn_flush_i = 1'b0;
        ecode_i      = '0;
        esubcode_i   = '0;
        era_i        = '0;
        hw_int_i     = '0;
        raddr_i      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // load ERA and the save registers before checking starts
        for (int i = 0; i <= N_SAVE; i++) begin
            wr1_we_i   = 1'b1;
            wr1_addr_i = (i == N_SAVE) ? csr_pkg::CSR_ERA : csr_pkg::CSR_SAVE0 + i;
            wr1_data_i = $random(seed);
            @(negedge clk);
        end
        wr1_we_i = 1'b0;

        for (int n = 0; n < N_CYCLES; n++) begin
            drive_cycle();
            #(CLK_PERIOD / 4);
            check_outputs();
            @(negedge clk);
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #((N_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in the expected time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: flist.f
src/csr_pkg.sv
src/csr_update_if.sv
src/csr_write_select.sv
src/csr_trap_regs.sv
src/csr_timer.sv
src/csr_read_mux.sv
src/csr_file_top.sv
testbench/csr_ref_model.sv
testbench/csr_tb.sv
